//--- source/alut_pkg.sv
package alut_pkg;

   // ------------------------------------------------------------
   // field widths
   // ------------------------------------------------------------
   localparam int mac_w   = 48;                 // ethernet mac address
   localparam int port_w  = 2;                  // four switch ports
   localparam int epoch_w = 16;                 // age timestamp
   localparam int hash_w  = 8;                  // table address

   // depth follows the hash width, direct mapped
   localparam int table_depth = 1 << hash_w;

   // last table index, used by the clear and the sweep
   localparam logic [hash_w-1:0] last_index = hash_w'(table_depth - 1);

   // ------------------------------------------------------------
   // entry layout: {valid, mac, port, epoch}
   // ------------------------------------------------------------
   localparam int entry_w = 1 + mac_w + port_w + epoch_w;   // 67 bits

   localparam int epoch_lsb = 0;                         // bottom field
   localparam int port_lsb  = epoch_lsb + epoch_w;
   localparam int mac_lsb   = port_lsb + port_w;
   localparam int valid_bit = mac_lsb + mac_w;           // top bit

   // ------------------------------------------------------------
   // hash: fold the mac into one table address
   // ------------------------------------------------------------
   // xor of all six bytes, so any single byte change moves the slot
   function automatic logic [hash_w-1:0] alut_hash
   (
      input logic [mac_w-1:0] mac
   );
      logic [hash_w-1:0] folded;
      folded = '0;
      for (int i = 0; i < mac_w / hash_w; i++)
      begin
         folded = folded ^ mac[i*hash_w +: hash_w];   // one byte per pass
      end
      return folded;
   endfunction

endpackage

//--- source/alut_mem.sv
`timescale 1ns/10ps

module alut_mem
(
   input  logic                          pclk19,
   // address checker side
   input  logic [alut_pkg::hash_w-1:0]   add_addr,    // hashed table address
   input  logic                          add_write,   // high = write
   input  logic [alut_pkg::entry_w-1:0]  add_wdata,
   output logic [alut_pkg::entry_w-1:0]  add_rdata,   // valid cycle after addr
   // age checker side
   input  logic [alut_pkg::hash_w-1:0]   age_addr,
   input  logic                          age_write,
   input  logic [alut_pkg::entry_w-1:0]  age_wdata,
   output logic [alut_pkg::entry_w-1:0]  age_rdata
);

   // table storage, no reset, the age checker clears valid bits
   logic [alut_pkg::entry_w-1:0] mem_array [alut_pkg::table_depth];

   // ------------------------------------------------------------
   // one access per side per cycle
   // ------------------------------------------------------------
   // reads see the pre-edge contents, so a same-cycle write
   // to the read address returns the old entry
   always_ff @(posedge pclk19)
   begin
      // age side first
      if (age_write)
         mem_array[age_addr] <= age_wdata;
      else
         age_rdata <= mem_array[age_addr];     // registered read

      // add side last, wins a same-address write collision
      if (add_write)
         mem_array[add_addr] <= add_wdata;
      else
         add_rdata <= mem_array[add_addr];
   end

endmodule

//--- source/alut_addr_checker.sv
`timescale 1ns/10ps

module alut_addr_checker
(
   input  logic                          pclk19,
   input  logic                          rst,
   // frame descriptor
   input  logic                          frame_valid,   // one-cycle strobe
   input  logic [alut_pkg::mac_w-1:0]    src_mac,
   input  logic [alut_pkg::mac_w-1:0]    dst_mac,
   input  logic [alut_pkg::port_w-1:0]   src_port,
   // from age checker
   input  logic [alut_pkg::epoch_w-1:0]  cur_epoch,     // stamp for learned entries
   input  logic                          init_done,
   // table access
   output logic [alut_pkg::hash_w-1:0]   add_addr,
   output logic                          add_write,
   output logic [alut_pkg::entry_w-1:0]  add_wdata,
   input  logic [alut_pkg::entry_w-1:0]  add_rdata,
   // lookup result
   output logic                          lookup_valid,  // pulse, 3 cycles after accept
   output logic                          lookup_hit,
   output logic [alut_pkg::port_w-1:0]   lookup_port,
   output logic                          busy
);

   typedef enum logic [1:0]
   {
      st_idle,
      st_rd_dst,     // dst hash on the table address
      st_learn,      // dst entry back, src entry written
      st_report      // result goes out on the next edge
   } state_t;

   state_t state;

   // captured frame
   logic [alut_pkg::mac_w-1:0]   src_mac_r;
   logic [alut_pkg::mac_w-1:0]   dst_mac_r;
   logic [alut_pkg::port_w-1:0]  src_port_r;
   logic [alut_pkg::hash_w-1:0]  src_hash;
   logic [alut_pkg::hash_w-1:0]  dst_hash;

   // returned entry fields
   logic [alut_pkg::mac_w-1:0]   entry_mac;
   logic [alut_pkg::port_w-1:0]  entry_port;
   logic                         entry_hit;

   logic                         accept;

   // ------------------------------------------------------------
   // frame acceptance
   // ------------------------------------------------------------
   assign busy   = (state != st_idle);
   // frames during busy or before the init clear are dropped
   assign accept = frame_valid & ~busy & init_done;

   // descriptor and both hashes latched once per accepted frame
   always_ff @(posedge pclk19)
   begin
      if (accept)
      begin
         src_mac_r  <= src_mac;
         dst_mac_r  <= dst_mac;
         src_port_r <= src_port;
         src_hash   <= alut_pkg::alut_hash(src_mac);
         dst_hash   <= alut_pkg::alut_hash(dst_mac);
      end
   end

   // ------------------------------------------------------------
   // table access
   // ------------------------------------------------------------
   // dst read happens one cycle ahead of the src write, so the
   // lookup sees the table before this frame's learning
   assign add_addr  = (state == st_learn) ? src_hash : dst_hash;
   assign add_write = (state == st_learn);
   assign add_wdata = {1'b1, src_mac_r, src_port_r, cur_epoch};   // fresh entry

   assign entry_mac  = add_rdata[alut_pkg::mac_lsb +: alut_pkg::mac_w];
   assign entry_port = add_rdata[alut_pkg::port_lsb +: alut_pkg::port_w];
   // hit needs a valid entry holding exactly this mac, a collider misses
   assign entry_hit  = add_rdata[alut_pkg::valid_bit] && (entry_mac == dst_mac_r);

   // ------------------------------------------------------------
   // sequencer
   // ------------------------------------------------------------
   always_ff @(posedge pclk19)
   begin
      if (rst)
      begin
         state        <= st_idle;
         lookup_valid <= 1'b0;
         lookup_hit   <= 1'b0;
         lookup_port  <= '0;
      end
      else
      begin
         lookup_valid <= 1'b0;                   // pulse by default
         case (state)
            st_idle:
            begin
               if (accept)
                  state <= st_rd_dst;
            end
            st_rd_dst:
            begin
               state <= st_learn;                // read data lands next cycle
            end
            st_learn:
            begin
               state       <= st_report;
               lookup_hit  <= entry_hit;
               lookup_port <= entry_hit ? entry_port : '0;   // zero on a miss
            end
            st_report:
            begin
               state        <= st_idle;          // busy drops with the pulse
               lookup_valid <= 1'b1;
            end
            default:
            begin
               state <= st_idle;
            end
         endcase
      end
   end

endmodule

//--- source/alut_age_checker.sv
`timescale 1ns/10ps

module alut_age_checker
(
   input  logic                          pclk19,
   input  logic                          rst,
   // control
   input  logic                          age_tick,      // advances the epoch
   input  logic                          sweep_start,   // pulse, idle only
   input  logic [alut_pkg::epoch_w-1:0]  max_age,
   output logic [alut_pkg::epoch_w-1:0]  cur_epoch,
   // table access
   output logic [alut_pkg::hash_w-1:0]   age_addr,
   output logic                          age_write,
   output logic [alut_pkg::entry_w-1:0]  age_wdata,
   input  logic [alut_pkg::entry_w-1:0]  age_rdata,
   // status
   output logic                          sweep_done,    // pulse after last entry
   output logic [alut_pkg::hash_w:0]     aged_count,    // removals of last sweep
   output logic                          init_done
);

   typedef enum logic [1:0]
   {
      st_init,       // post-reset valid clear, one entry per cycle
      st_idle,
      st_rd,         // sweep read
      st_dec         // sweep decide and maybe invalidate
   } state_t;

   state_t state;

   logic [alut_pkg::hash_w-1:0]   idx;          // shared by clear and sweep
   logic [alut_pkg::hash_w:0]     removed;      // running count for this sweep
   logic                          last_idx;
   logic [alut_pkg::epoch_w-1:0]  entry_age;
   logic                          entry_aged;
   logic [alut_pkg::entry_w-1:0]  stale_entry;

   // ------------------------------------------------------------
   // epoch counter
   // ------------------------------------------------------------
   always_ff @(posedge pclk19)
   begin
      if (rst)
         cur_epoch <= '0;
      else if (age_tick)
         cur_epoch <= cur_epoch + 1'b1;        // ticks count during sweeps too
   end

   // ------------------------------------------------------------
   // age decision on the returned entry
   // ------------------------------------------------------------
   // modulo subtraction handles epoch wrap
   assign entry_age  = cur_epoch - age_rdata[alut_pkg::epoch_lsb +: alut_pkg::epoch_w];
   assign entry_aged = age_rdata[alut_pkg::valid_bit] && (entry_age > max_age);

   // same entry with only the valid bit dropped
   always_comb
   begin
      stale_entry                      = age_rdata;
      stale_entry[alut_pkg::valid_bit] = 1'b0;
   end

   assign last_idx  = (idx == alut_pkg::last_index);
   assign init_done = (state != st_init);      // low through reset and clear

   // table access
   assign age_addr  = idx;
   assign age_write = (state == st_init) || ((state == st_dec) && entry_aged);
   assign age_wdata = (state == st_init) ? '0 : stale_entry;   // init writes all zero

   // ------------------------------------------------------------
   // clear and sweep sequencer
   // ------------------------------------------------------------
   always_ff @(posedge pclk19)
   begin
      if (rst)
      begin
         state      <= st_init;
         idx        <= '0;
         removed    <= '0;
         aged_count <= '0;
         sweep_done <= 1'b0;
      end
      else
      begin
         sweep_done <= 1'b0;
         case (state)
            st_init:
            begin
               idx <= idx + 1'b1;               // wraps back to 0 at the end
               if (last_idx)
                  state <= st_idle;
            end
            st_idle:
            begin
               // starts during init or a sweep never reach here
               if (sweep_start)
               begin
                  idx     <= '0;
                  removed <= '0;
                  state   <= st_rd;
               end
            end
            st_rd:
            begin
               state <= st_dec;                 // entry arrives next cycle
            end
            st_dec:
            begin
               removed <= removed + (alut_pkg::hash_w + 1)'(entry_aged);
               if (last_idx)
               begin
                  state      <= st_idle;
                  sweep_done <= 1'b1;
                  aged_count <= removed + (alut_pkg::hash_w + 1)'(entry_aged);
               end
               else
               begin
                  idx   <= idx + 1'b1;
                  state <= st_rd;
               end
            end
            default:
            begin
               state <= st_idle;
            end
         endcase
      end
   end

endmodule

//--- source/alut_top.sv
`timescale 1ns/10ps

module alut_top
(
   input  logic                          pclk19,
   input  logic                          rst,
   // frame in
   input  logic                          frame_valid,
   input  logic [alut_pkg::mac_w-1:0]    src_mac,
   input  logic [alut_pkg::mac_w-1:0]    dst_mac,
   input  logic [alut_pkg::port_w-1:0]   src_port,
   // lookup out
   output logic                          lookup_valid,
   output logic                          lookup_hit,
   output logic [alut_pkg::port_w-1:0]   lookup_port,
   output logic                          busy,
   // aging control
   input  logic                          age_tick,
   input  logic                          sweep_start,
   input  logic [alut_pkg::epoch_w-1:0]  max_age,
   // aging status
   output logic                          sweep_done,
   output logic [alut_pkg::hash_w:0]     aged_count,
   output logic                          init_done
);

   // ------------------------------------------------------------
   // internal nets
   // ------------------------------------------------------------
   logic [alut_pkg::hash_w-1:0]   add_addr;     // address checker port
   logic                          add_write;
   logic [alut_pkg::entry_w-1:0]  add_wdata;
   logic [alut_pkg::entry_w-1:0]  add_rdata;

   logic [alut_pkg::hash_w-1:0]   age_addr;     // age checker port
   logic                          age_write;
   logic [alut_pkg::entry_w-1:0]  age_wdata;
   logic [alut_pkg::entry_w-1:0]  age_rdata;

   logic [alut_pkg::epoch_w-1:0]  cur_epoch;    // single epoch source

   // ------------------------------------------------------------
   // blocks
   // ------------------------------------------------------------
   alut_mem u_mem
   (
      .pclk19     (pclk19),
      .add_addr   (add_addr),
      .add_write  (add_write),
      .add_wdata  (add_wdata),
      .add_rdata  (add_rdata),
      .age_addr   (age_addr),
      .age_write  (age_write),
      .age_wdata  (age_wdata),
      .age_rdata  (age_rdata)
   );

   alut_addr_checker u_addr_checker
   (
      .pclk19        (pclk19),
      .rst           (rst),
      .frame_valid   (frame_valid),
      .src_mac       (src_mac),
      .dst_mac       (dst_mac),
      .src_port      (src_port),
      .cur_epoch     (cur_epoch),
      .init_done     (init_done),     // holds frames off during the clear
      .add_addr      (add_addr),
      .add_write     (add_write),
      .add_wdata     (add_wdata),
      .add_rdata     (add_rdata),
      .lookup_valid  (lookup_valid),
      .lookup_hit    (lookup_hit),
      .lookup_port   (lookup_port),
      .busy          (busy)
   );

   alut_age_checker u_age_checker
   (
      .pclk19       (pclk19),
      .rst          (rst),
      .age_tick     (age_tick),
      .sweep_start  (sweep_start),
      .max_age      (max_age),
      .cur_epoch    (cur_epoch),
      .age_addr     (age_addr),
      .age_write    (age_write),
      .age_wdata    (age_wdata),
      .age_rdata    (age_rdata),
      .sweep_done   (sweep_done),
      .aged_count   (aged_count),
      .init_done    (init_done)
   );

endmodule

//--- testbench/alut_sva.sv
`timescale 1ns/10ps

module alut_sva
(
   input  logic  pclk19,
   input  logic  rst,
   input  logic  lookup_valid,
   input  logic  busy,
   input  logic  sweep_done,
   input  logic  init_done,
   input  logic  add_write      // internal net of alut_top
);

   // ------------------------------------------------------------
   // lookup side
   // ------------------------------------------------------------
   a_valid_pulse : assert property (@(posedge pclk19) disable iff (rst)
      lookup_valid |=> !lookup_valid)
      else $error("lookup_valid high for two cycles in a row");

   // busy already down while the result is out
   a_busy_drop : assert property (@(posedge pclk19) disable iff (rst)
      lookup_valid |-> !busy)
      else $error("busy still high with lookup_valid");

   a_write_busy : assert property (@(posedge pclk19) disable iff (rst)
      add_write |-> busy)   // learning only inside a lookup
      else $error("add_write high while address checker idle");

   // ------------------------------------------------------------
   // age side
   // ------------------------------------------------------------
   a_sweep_init : assert property (@(posedge pclk19) disable iff (rst)
      sweep_done |-> init_done)
      else $error("sweep_done during init clear");

endmodule

bind alut_top alut_sva u_sva
(
   .pclk19        (pclk19),
   .rst           (rst),
   .lookup_valid  (lookup_valid),
   .busy          (busy),
   .sweep_done    (sweep_done),
   .init_done     (init_done),
   .add_write     (add_write)
);

//--- testbench/tb_alut.sv
`timescale 1ns/10ps

module tb_alut;

   logic                          pclk19;
   logic                          rst;
   logic                          frame_valid;
   logic [alut_pkg::mac_w-1:0]    src_mac;
   logic [alut_pkg::mac_w-1:0]    dst_mac;
   logic [alut_pkg::port_w-1:0]   src_port;
   logic                          lookup_valid;
   logic                          lookup_hit;
   logic [alut_pkg::port_w-1:0]   lookup_port;
   logic                          busy;
   logic                          age_tick;
   logic                          sweep_start;
   logic [alut_pkg::epoch_w-1:0]  max_age;
   logic                          sweep_done;
   logic [alut_pkg::hash_w:0]     aged_count;
   logic                          init_done;

   // table model with one slot per hash value
   bit                            m_valid [alut_pkg::table_depth];
   logic [alut_pkg::mac_w-1:0]    m_mac   [alut_pkg::table_depth];
   logic [alut_pkg::port_w-1:0]   m_port  [alut_pkg::table_depth];
   logic [alut_pkg::epoch_w-1:0]  m_epoch [alut_pkg::table_depth];
   logic [alut_pkg::epoch_w-1:0]  model_epoch;   // follows our own age_tick pulses

   logic [alut_pkg::mac_w-1:0]    pool [24];      // mac pool where pairs i and i+12 collide
   logic [31:0]                   lfsr_state = 32'hc28a_7bd1;
   int                            cyc = 0;
   int                            errors = 0;
   int                            frames = 0;
   int                            sweeps = 0;

   alut_top uut
   (
      .pclk19        (pclk19),
      .rst           (rst),
      .frame_valid   (frame_valid),
      .src_mac       (src_mac),
      .dst_mac       (dst_mac),
      .src_port      (src_port),
      .lookup_valid  (lookup_valid),
      .lookup_hit    (lookup_hit),
      .lookup_port   (lookup_port),
      .busy          (busy),
      .age_tick      (age_tick),
      .sweep_start   (sweep_start),
      .max_age       (max_age),
      .sweep_done    (sweep_done),
      .aged_count    (aged_count),
      .init_done     (init_done)
   );

   initial
   begin
      pclk19 = 1'b0;
      forever #2 pclk19 = ~pclk19;   // 4 ns period
   end

   always @(posedge pclk19)
      cyc <= cyc + 1;                // latency reference

   // ------------------------------------------------------------
   // random source and hash
   // ------------------------------------------------------------
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32+x^22+x^2+x+1
   endfunction

   task automatic take_bits(input int n, output logic [63:0] val);
      val = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         val = {val[62:0], lfsr_state[0]};   // one step per bit
      end
   endtask

   // xor of the six mac bytes
   function automatic logic [7:0] slot_of(input logic [47:0] mac);
      return mac[47:40] ^ mac[39:32] ^ mac[31:24] ^ mac[23:16] ^ mac[15:8] ^ mac[7:0];
   endfunction

   // ------------------------------------------------------------
   // frame, tick and sweep drivers
   // ------------------------------------------------------------
   task automatic send_frame(input int s, input int d, input logic [1:0] p, input bit drop);
      logic [7:0]  ds;
      logic [7:0]  ss;
      logic        exp_hit;
      logic [1:0]  exp_port;
      int          start;
      int          n;
      bit          seen;
      ds = slot_of(pool[d]);
      ss = slot_of(pool[s]);
      exp_hit  = m_valid[ds] && (m_mac[ds] == pool[d]);   // table before learning
      exp_port = exp_hit ? m_port[ds] : 2'd0;
      @(posedge pclk19);
      frame_valid <= 1'b1;
      src_mac     <= pool[s];
      dst_mac     <= pool[d];
      src_port    <= p;
      @(posedge pclk19);                        // accept edge
      if (drop)
      begin
         src_mac  <= pool[(s + 5) % 24];        // second strobe lands on busy
         src_port <= ~p;
      end
      else
         frame_valid <= 1'b0;
      @(negedge pclk19);
      start = cyc;
      if (busy !== 1'b1)
      begin
         $display("ERR busy exp %h got %h", 1'b1, busy);
         errors++;
      end
      if (drop)
      begin
         @(posedge pclk19);
         frame_valid <= 1'b0;
      end
      n = 0;
      seen = 1'b0;
      while (!seen && n < 16)
      begin
         @(negedge pclk19);
         n++;
         seen = (lookup_valid === 1'b1);
      end
      if (!seen)
      begin
         $display("timeout waiting for lookup_valid after an accepted frame");
         errors++;
      end
      else
      begin
         if (cyc - start != 3)
         begin
            $display("ERR lookup_valid latency exp %h got %h", 3, cyc - start);
            errors++;
         end
         if (lookup_hit !== exp_hit)
         begin
            $display("ERR lookup_hit exp %h got %h", exp_hit, lookup_hit);
            errors++;
         end
         if (lookup_port !== exp_port)
         begin
            $display("ERR lookup_port exp %h got %h", exp_port, lookup_port);
            errors++;
         end
         if (busy !== 1'b0)
         begin
            $display("ERR busy exp %h got %h", 1'b0, busy);
            errors++;
         end
      end
      m_valid[ss] = 1'b1;                       // source replaces whatever sat there
      m_mac[ss]   = pool[s];
      m_port[ss]  = p;
      m_epoch[ss] = model_epoch;
      frames++;
      repeat (5)
      begin
         @(negedge pclk19);
         if (lookup_valid === 1'b1)
         begin
            $display("unexpected lookup_valid, a dropped frame was answered");
            errors++;
         end
      end
   endtask

   task automatic tick_epoch();
      @(posedge pclk19);
      age_tick <= 1'b1;
      @(posedge pclk19);
      age_tick <= 1'b0;
      model_epoch = model_epoch + 1'b1;
   endtask

   task automatic run_sweep(input logic [15:0] limit);
      logic [alut_pkg::hash_w:0]     exp_count;
      logic [alut_pkg::epoch_w-1:0]  age_diff;
      int                            n;
      bit                            seen;
      exp_count = '0;
      for (int i = 0; i < alut_pkg::table_depth; i++)
      begin
         age_diff = model_epoch - m_epoch[i];   // wraps like the epoch
         if (m_valid[i] && age_diff > limit)
         begin
            m_valid[i] = 1'b0;
            exp_count = exp_count + 1'b1;
         end
      end
      @(posedge pclk19);
      max_age     <= limit;
      sweep_start <= 1'b1;
      @(posedge pclk19);
      sweep_start <= 1'b0;
      n = 0;
      seen = 1'b0;
      while (!seen && n < 700)                  // 2 cycles per entry plus margin
      begin
         @(negedge pclk19);
         n++;
         seen = (sweep_done === 1'b1);
      end
      if (!seen)
      begin
         $display("timeout waiting for sweep_done");
         errors++;
      end
      else if (aged_count !== exp_count)
      begin
         $display("ERR aged_count exp %h got %h", exp_count, aged_count);
         errors++;
      end
      sweeps++;
   endtask

   // ------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------
   initial
   begin
      logic [63:0]  r;
      int           s;
      int           d;
      int           n;
      rst = 1'b1;
      frame_valid = 1'b0;
      src_mac = '0;
      dst_mac = '0;
      src_port = '0;
      age_tick = 1'b0;
      sweep_start = 1'b0;
      max_age = '0;
      model_epoch = '0;
      for (int i = 0; i < alut_pkg::table_depth; i++)
         m_valid[i] = 1'b0;                     // init clear leaves all invalid
      for (int i = 0; i < 12; i++)
      begin
         take_bits(48, r);
         pool[i]      = r[47:0];
         pool[i + 12] = r[47:0] ^ 48'h0101_0000_0000;   // equal byte xor keeps the slot
      end
      repeat (15) @(posedge pclk19);
      @(negedge pclk19);
      if ({lookup_valid, busy, sweep_done, aged_count, init_done} !== '0)
      begin
         $display("outputs not idle during reset");
         errors++;
      end
      @(posedge pclk19);
      rst <= 1'b0;
      n = 0;
      while (init_done !== 1'b1 && n < 300)
      begin
         @(negedge pclk19);
         n++;
      end
      if (init_done !== 1'b1)
      begin
         $display("timeout waiting for init_done");
         errors++;
      end

      // directed frames for unknown dst, learn, self lookup and collision replace
      send_frame(0, 1, 2'd1, 1'b0);
      send_frame(1, 0, 2'd2, 1'b0);
      send_frame(0, 0, 2'd3, 1'b0);
      send_frame(2, 0, 2'd0, 1'b0);
      send_frame(12, 3, 2'd2, 1'b1);
      send_frame(4, 17, 2'd1, 1'b0);            // dropped source 17 must still miss
      send_frame(3, 0, 2'd0, 1'b0);

      // random traffic, ticks and sweeps
      for (int round = 0; round < 3; round++)
      begin
         for (int k = 0; k < 40; k++)
         begin
            take_bits(5, r);
            s = int'(r[4:0]) % 24;
            take_bits(5, r);
            d = int'(r[4:0]) % 24;
            take_bits(5, r);
            send_frame(s, d, r[1:0], r[4:2] == 3'd0);
            take_bits(2, r);
            if (r[1])
               repeat (int'(r[0]) + 1) tick_epoch();
         end
         take_bits(4, r);
         run_sweep({12'd0, r[3:0]});
         for (int i = 0; i < 24; i++)
            send_frame(i, i, 2'(i), 1'b0);      // aged macs must miss here
      end

      $display("frames %0d, sweeps %0d, errors %0d", frames, sweeps, errors);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

//--- project.f
source/alut_pkg.sv
source/alut_mem.sv
source/alut_addr_checker.sv
source/alut_age_checker.sv
source/alut_top.sv
testbench/alut_sva.sv
testbench/tb_alut.sv

//--- Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP        = tb_alut
FILELIST   = project.f
LOG        = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "No errors" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
